/* hdl/zx_mem_pkg.sv */
/* Shared types and constants for the Spectrum paging and SDRAM access path.
   Imported by every RTL module of the pipeline. */
`default_nettype none

package zx_mem_pkg;

	// ==================================================
	// Address geometry
	// ==================================================
	localparam int SDRAM_ADDR_W = 24; // SDRAM byte address
	localparam int BANK_W       = 14; // Offset inside a 16K bank

	// Default regions in SDRAM
	localparam logic [SDRAM_ADDR_W-1:0] DEF_ROM_BASE = 24'h10_0000; // 4 ROM banks
	localparam logic [SDRAM_ADDR_W-1:0] DEF_RAM_BASE = 24'h00_0000; // 8 RAM banks

	// Machine model, fixed at reset
	typedef enum logic [1:0] {
		MACH_48    = 2'd0,
		MACH_128   = 2'd1,
		MACH_PLUS3 = 2'd2
	} machine_t;

	// ==================================================
	// Pipeline payloads
	// ==================================================
	// Raw CPU bus, strobes active high
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;  // CPU write data
		logic        mreq;
		logic        iorq;
		logic        rd;
		logic        wr;
	} cpu_bus_t;

	typedef enum logic [1:0] {
		OP_MEM_RD = 2'd0,
		OP_MEM_WR = 2'd1,
		OP_IO_WR  = 2'd2
	} bus_kind_t;

	// One bus operation per CPU cycle
	typedef struct packed {
		logic        valid;
		bus_kind_t   kind;
		logic [15:0] addr;
		logic [7:0]  data;
	} bus_op_t;

	// Translated request, byte addressed
	typedef struct packed {
		logic                    valid;
		logic                    we;
		logic [SDRAM_ADDR_W-1:0] addr;
		logic [7:0]              data;
	} mem_req_t;

	// Word-wide SDRAM command
	typedef struct packed {
		logic [SDRAM_ADDR_W-2:0] a;  // Word address
		logic [1:0]              ds; // Bit 1 is the upper byte
		logic [15:0]             d;
		logic                    we;
	} sdram_cmd_t;

endpackage

`default_nettype wire

/* hdl/cpu_bus_sync.sv */
/* Stage 1 of the memory path. Turns rising CPU strobes into single
   bus operations, one per CPU cycle. */
`timescale 1ns/100ps
`default_nettype none

module cpu_bus_sync import zx_mem_pkg::*; (
	input  wire      clk_sys,
	input  wire      reset,
	input  wire      cpu_bus_t cpu_bus,
	output bus_op_t  bus_op
);

	logic [2:0]  qual_now;  // {io_wr, mem_wr, mem_rd}
	logic [2:0]  qual_cur;  // Sampled at the strobe edge
	logic [2:0]  qual_prev;
	logic [2:0]  rise;
	logic [15:0] addr_cap;
	logic [7:0]  data_cap;

	// Qualified strobes
	assign qual_now = {
		cpu_bus.iorq & cpu_bus.wr,
		cpu_bus.mreq & cpu_bus.wr,
		cpu_bus.mreq & cpu_bus.rd
	};

	// A held strobe rises only once
	assign rise = qual_cur & ~qual_prev;

	// ==================================================
	// Capture and edge detect
	// ==================================================
	always_ff @(posedge clk_sys) begin
		addr_cap <= cpu_bus.addr; // Taken with the qualifiers
		data_cap <= cpu_bus.data;

		bus_op.addr <= addr_cap;
		bus_op.data <= data_cap;
		if (rise[0]) begin
			bus_op.kind <= OP_MEM_RD;
		end else if (rise[1]) begin
			bus_op.kind <= OP_MEM_WR;
		end else begin
			bus_op.kind <= OP_IO_WR;
		end

		if (reset) begin
			qual_cur     <= 3'b000;
			qual_prev    <= 3'b000;
			bus_op.valid <= 1'b0;
		end else begin
			qual_cur     <= qual_now;
			qual_prev    <= qual_cur;
			bus_op.valid <= |rise; // Single cycle pulse
		end
	end

endmodule

`default_nettype wire

/* hdl/zx_paging.sv */
/* Stage 2 of the memory path. Holds the 7FFD and 1FFD paging registers and
   maps CPU addresses onto the ROM and RAM regions of the SDRAM. */
`timescale 1ns/100ps
`default_nettype none

module zx_paging import zx_mem_pkg::*; #(
	parameter logic [SDRAM_ADDR_W-1:0] ROM_BASE = DEF_ROM_BASE,
	parameter logic [SDRAM_ADDR_W-1:0] RAM_BASE = DEF_RAM_BASE
) (
	input  wire       clk_sys,
	input  wire       reset,
	input  wire       machine_t machine,
	input  wire       bus_op_t bus_op,
	output mem_req_t  mem_req
);

	localparam int ROM_PAD = SDRAM_ADDR_W - BANK_W - 2;
	localparam int RAM_PAD = SDRAM_ADDR_W - BANK_W - 3;

	machine_t mach;
	logic [7:0] page_7ffd;
	logic [7:0] page_1ffd;

	logic       locked;
	logic       wr_7ffd;
	logic       wr_1ffd;
	logic       special;
	logic [1:0] slot;
	logic [1:0] rom_bank;
	logic [2:0] ram_bank;
	logic       is_rom;
	logic       is_mem;
	logic       is_wr;
	logic [SDRAM_ADDR_W-1:0] rom_addr;
	logic [SDRAM_ADDR_W-1:0] ram_addr;

	// ==================================================
	// Port decode
	// ==================================================
	assign locked = (mach == MACH_48) | page_7ffd[5];

	// Partial decode as on the real machines
	assign wr_7ffd = ~bus_op.addr[15] & ~bus_op.addr[1]
		& (bus_op.addr[14] | (mach != MACH_PLUS3));
	assign wr_1ffd = (mach == MACH_PLUS3) & (bus_op.addr[15:12] == 4'b0001)
		& ~bus_op.addr[1];

	assign special = page_1ffd[0]; // +3 all-RAM mode
	assign slot    = bus_op.addr[15:14];

	// ROM bank per machine
	always_comb begin
		case (mach)
			MACH_128:   rom_bank = {1'b0, page_7ffd[4]};
			MACH_PLUS3: rom_bank = {page_1ffd[2], page_7ffd[4]};
			default:    rom_bank = 2'd0;
		endcase
	end

	// RAM bank for the addressed slot
	always_comb begin
		if (special) begin
			case ({page_1ffd[2:1], slot})
				4'b00_00: ram_bank = 3'd0;
				4'b00_01: ram_bank = 3'd1;
				4'b00_10: ram_bank = 3'd2;
				4'b00_11: ram_bank = 3'd3;
				4'b10_11: ram_bank = 3'd3;
				4'b11_01: ram_bank = 3'd7;
				4'b11_11: ram_bank = 3'd3;
				default:  ram_bank = {1'b1, slot}; // 4, 5, 6, 7 pattern
			endcase
		end else begin
			case (slot)
				2'd1:    ram_bank = 3'd5;
				2'd2:    ram_bank = 3'd2;
				2'd3:    ram_bank = page_7ffd[2:0]; // Locked at 0 on 48K
				default: ram_bank = 3'd0; // Slot 0 is ROM here
			endcase
		end
	end

	// ==================================================
	// Address translation
	// ==================================================
	assign rom_addr = ROM_BASE
		+ {{ROM_PAD{1'b0}}, rom_bank, bus_op.addr[BANK_W-1:0]};
	assign ram_addr = RAM_BASE
		+ {{RAM_PAD{1'b0}}, ram_bank, bus_op.addr[BANK_W-1:0]};

	assign is_rom = ~special & (slot == 2'd0);
	assign is_mem = (bus_op.kind == OP_MEM_RD) | (bus_op.kind == OP_MEM_WR);
	assign is_wr  = (bus_op.kind == OP_MEM_WR);

	always_ff @(posedge clk_sys) begin
		mem_req.we   <= is_wr;
		mem_req.addr <= is_rom ? rom_addr : ram_addr;
		mem_req.data <= bus_op.data;

		if (reset) begin
			mach         <= machine; // Model fixed while in reset
			page_7ffd    <= 8'h00;
			page_1ffd    <= 8'h00;
			mem_req.valid <= 1'b0;
		end else begin
			// ROM writes vanish here
			mem_req.valid <= bus_op.valid & is_mem & ~(is_wr & is_rom);

			if (bus_op.valid && bus_op.kind == OP_IO_WR && !locked) begin
				if (wr_7ffd) begin
					page_7ffd <= bus_op.data;
				end else if (wr_1ffd) begin
					page_1ffd <= bus_op.data;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/sdram_port.sv */
/* Stage 3 of the memory path. Issues byte requests to the 16-bit SDRAM port
   with a toggle handshake and returns the read byte and ready to the CPU. */
`timescale 1ns/100ps
`default_nettype none

module sdram_port import zx_mem_pkg::*; (
	input  wire         clk_sys,
	input  wire         reset,
	input  wire         mem_req_t mem_req,

	output sdram_cmd_t  sdram_cmd,
	output logic        sdram_req,
	input  wire         sdram_ack,
	input  wire  [15:0] sdram_dout,

	output logic [7:0]  cpu_din,
	output logic        ram_ready
);

	logic lane_hi; // Byte 0 or 1 of the word

	// ==================================================
	// Request issue
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (mem_req.valid) begin
			sdram_cmd.a  <= mem_req.addr[SDRAM_ADDR_W-1:1];
			sdram_cmd.we <= mem_req.we;
			sdram_cmd.d  <= {mem_req.data, mem_req.data}; // Same byte on both lanes

			// Reads fetch the whole word
			if (mem_req.we) begin
				sdram_cmd.ds <= {mem_req.addr[0], ~mem_req.addr[0]};
			end else begin
				sdram_cmd.ds <= 2'b11;
			end

			lane_hi <= mem_req.addr[0];
		end

		if (reset) begin
			sdram_req <= 1'b0;
		end else if (mem_req.valid) begin
			sdram_req <= ~sdram_req; // New request
		end
	end

	// Idle once the memory has caught up
	assign ram_ready = (sdram_ack == sdram_req);

	// Read byte selection
	assign cpu_din = lane_hi ? sdram_dout[15:8] : sdram_dout[7:0];

endmodule

`default_nettype wire

/* hdl/zx_mem_top.sv */
/* Top of the Spectrum memory path: bus capture, paging and SDRAM port in
   a chain. The SDRAM region bases are set here. */
`timescale 1ns/100ps
`default_nettype none

module zx_mem_top import zx_mem_pkg::*; #(
	parameter logic [SDRAM_ADDR_W-1:0] ROM_BASE = DEF_ROM_BASE,
	parameter logic [SDRAM_ADDR_W-1:0] RAM_BASE = DEF_RAM_BASE
) (
	input  wire         clk_sys,
	input  wire         reset,
	input  wire         machine_t machine, // Sampled during reset

	input  wire         cpu_bus_t cpu_bus,
	output logic [7:0]  cpu_din,
	output logic        ram_ready,

	output sdram_cmd_t  sdram_cmd,
	output logic        sdram_req,         // Toggle
	input  wire         sdram_ack,         // Toggle
	input  wire  [15:0] sdram_dout
);

	bus_op_t  bus_op;
	mem_req_t mem_req;

	// ==================================================
	// Stage chain
	// ==================================================
	cpu_bus_sync bus_sync_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.cpu_bus (cpu_bus),
		.bus_op  (bus_op)
	);

	zx_paging #(
		.ROM_BASE (ROM_BASE),
		.RAM_BASE (RAM_BASE)
	) paging_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.machine (machine),
		.bus_op  (bus_op),
		.mem_req (mem_req)
	);

	sdram_port port_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.mem_req    (mem_req),
		.sdram_cmd  (sdram_cmd),
		.sdram_req  (sdram_req),
		.sdram_ack  (sdram_ack),
		.sdram_dout (sdram_dout),
		.cpu_din    (cpu_din),
		.ram_ready  (ram_ready)
	);

endmodule

`default_nettype wire

/* dv/tb_zx_mem_tasks.svh */
/* Bus drive, checks and directed tests, included inside the testbench
   module so that they reach its signals. */
`ifndef TB_ZX_MEM_TASKS_SVH
`define TB_ZX_MEM_TASKS_SVH

// Contents of a word never written
function automatic logic [15:0] fill_word(input logic [22:0] a);
	return a[15:0] ^ {a[22:15], 1'b1, a[22:16]};
endfunction

// Word address from the paging rules
function automatic logic [31:0] word_addr(input logic [23:0] base, input int bank,
		input logic [15:0] addr);
	logic [31:0] byte_addr;
	byte_addr = 32'(base) + 32'(bank) * 32'd16384 + 32'(addr[13:0]);
	return byte_addr >> 1;
endfunction

// +3 special mode bank table
function automatic int special_bank(input int mode, input int slot);
	int table_banks [4][4];
	table_banks = '{'{0, 1, 2, 3}, '{4, 5, 6, 7}, '{4, 5, 6, 3}, '{4, 7, 6, 3}};
	return table_banks[mode][slot];
endfunction

task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
	if (got !== exp) begin
		$display("MISMATCH at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
		$display("SIMULATION FAILED");
		$fatal(1, "check failed");
	end
endtask

task automatic apply_reset(input machine_t m);
	@(posedge clk_sys);
	#STIM_DLY;
	machine = m;
	cpu_bus = '0;
	reset   = 1'b1;
	repeat (5) @(posedge clk_sys);
	#STIM_DLY;
	reset = 1'b0;
endtask

// One strobe cycle, held until ram_ready returns
task automatic bus_cycle(input logic [15:0] addr, input logic [7:0] data,
		input logic mreq, input logic rd);
	int waited;
	@(posedge clk_sys);
	#STIM_DLY;
	cpu_bus.addr = addr;
	cpu_bus.data = data;
	cpu_bus.mreq = mreq;
	cpu_bus.iorq = ~mreq;
	cpu_bus.rd   = rd;
	cpu_bus.wr   = ~rd;
	repeat (4) @(posedge clk_sys);
	#SAMPLE_DLY;
	waited = 0;
	while (!ram_ready) begin
		if (waited == READY_TIMEOUT) begin
			$display("Timeout: ram_ready stayed low after access at 0x%0h", addr);
			$display("SIMULATION FAILED");
			$fatal(1, "timeout");
		end
		@(posedge clk_sys);
		#SAMPLE_DLY;
		waited = waited + 1;
	end
	cpu_bus = '0;
	repeat (2) @(posedge clk_sys);
endtask

task automatic io_write(input logic [15:0] port, input logic [7:0] data);
	bus_cycle(port, data, 1'b0, 1'b0);
endtask

task automatic mem_write(input logic [15:0] addr, input logic [7:0] data);
	bus_cycle(addr, data, 1'b1, 1'b0);
endtask

task automatic mem_read(input logic [15:0] addr, output logic [7:0] data);
	bus_cycle(addr, 8'h00, 1'b1, 1'b1);
	data = cpu_din; // Held until the next request
endtask

// ==================================================
// Directed tests
// ==================================================
task automatic test_ram_banking();
	logic [7:0]  rd;
	logic [15:0] a;
	apply_reset(MACH_128);
	a = 16'hc124;
	for (int b = 0; b < 8; b++) begin
		io_write(16'h7ffd, 8'(b));
		mem_write(a, 8'h30 + 8'(b));
		check_value("sdram_cmd.a", 32'(last_cmd.a), word_addr(RAM_BASE, b, a));
	end
	for (int b = 0; b < 8; b++) begin
		io_write(16'h7ffd, 8'(b));
		mem_read(a, rd);
		check_value("sdram_cmd.a", 32'(last_cmd.a), word_addr(RAM_BASE, b, a));
		check_value("cpu_din", 32'(rd), 32'(8'h30 + 8'(b)));
	end
endtask

task automatic test_rom_select();
	logic [7:0] rd;
	int         count;
	apply_reset(MACH_128);
	io_write(16'h7ffd, 8'h00);
	mem_read(16'h0000, rd);
	check_value("sdram_cmd.a", 32'(last_cmd.a), word_addr(ROM_BASE, 0, 16'h0000));
	io_write(16'h7ffd, 8'h10);
	mem_read(16'h0000, rd);
	check_value("sdram_cmd.a", 32'(last_cmd.a), word_addr(ROM_BASE, 1, 16'h0000));
	count = req_count;
	mem_write(16'h0100, 8'hee);
	check_value("req_count", 32'(req_count), 32'(count));
endtask

task automatic test_lock();
	logic [7:0] rd;
	apply_reset(MACH_128);
	io_write(16'h7ffd, 8'h03);
	io_write(16'h7ffd, 8'h24); // Bank 4 and lock
	io_write(16'h7ffd, 8'h01);
	mem_read(16'hc000, rd);
	check_value("sdram_cmd.a", 32'(last_cmd.a), word_addr(RAM_BASE, 4, 16'hc000));
	apply_reset(MACH_128);
	io_write(16'h7ffd, 8'h06);
	mem_read(16'hc000, rd);
	check_value("sdram_cmd.a", 32'(last_cmd.a), word_addr(RAM_BASE, 6, 16'hc000));
	apply_reset(MACH_48);
	io_write(16'h7ffd, 8'h07);
	mem_read(16'hc000, rd);
	check_value("sdram_cmd.a", 32'(last_cmd.a), word_addr(RAM_BASE, 0, 16'hc000));
endtask

task automatic test_plus3_special();
	logic [7:0]  rd;
	logic [15:0] a;
	int          count;
	apply_reset(MACH_PLUS3);
	for (int m = 0; m < 4; m++) begin
		io_write(16'h1ffd, 8'({m, 1'b1}));
		for (int s = 0; s < 4; s++) begin
			a = 16'(s * 16384 + 16'h0010);
			mem_read(a, rd);
			check_value("sdram_cmd.a", 32'(last_cmd.a),
				word_addr(RAM_BASE, special_bank(m, s), a));
		end
		count = req_count;
		mem_write(16'h0020, 8'(m));
		check_value("req_count", 32'(req_count), 32'(count + 1));
	end
	for (int rb = 0; rb < 4; rb++) begin
		io_write(16'h1ffd, (rb >= 2) ? 8'h04 : 8'h00);
		io_write(16'h7ffd, (rb % 2 == 1) ? 8'h10 : 8'h00);
		mem_read(16'h0000, rd);
		check_value("sdram_cmd.a", 32'(last_cmd.a), word_addr(ROM_BASE, rb, 16'h0000));
	end
endtask

task automatic test_byte_lanes();
	logic [7:0] rd;
	apply_reset(MACH_128);
	io_write(16'h7ffd, 8'h00);
	mem_write(16'hc200, 8'ha5);
	check_value("sdram_cmd.ds", 32'(last_cmd.ds), 32'h1);
	check_value("sdram_cmd.d", 32'(last_cmd.d), 32'ha5a5);
	check_value("sdram_cmd.we", 32'(last_cmd.we), 32'h1);
	mem_write(16'hc201, 8'h5a);
	check_value("sdram_cmd.ds", 32'(last_cmd.ds), 32'h2);
	mem_read(16'hc200, rd);
	check_value("sdram_cmd.ds", 32'(last_cmd.ds), 32'h3);
	check_value("cpu_din", 32'(rd), 32'ha5);
	mem_read(16'hc201, rd);
	check_value("cpu_din", 32'(rd), 32'h5a);
endtask

`endif

/* dv/tb_zx_mem.sv */
/* Testbench for the Spectrum memory path. Drives the CPU bus, models a
   word-wide SDRAM with a toggle handshake and runs the directed tests. */
`timescale 1ns/100ps
`default_nettype none

module tb_zx_mem import zx_mem_pkg::*; ();

	localparam logic [SDRAM_ADDR_W-1:0] ROM_BASE = 24'h04_0000;
	localparam logic [SDRAM_ADDR_W-1:0] RAM_BASE = 24'h08_0000;
	localparam int CLK_HALF  = 20;
	localparam int STIM_DLY  = 1;  // After the rising edge
	localparam int SAMPLE_DLY = 5;
	localparam int READY_TIMEOUT = 50;

	logic        clk_sys;
	logic        reset;
	machine_t    machine;
	cpu_bus_t    cpu_bus;
	logic [7:0]  cpu_din;
	logic        ram_ready;
	sdram_cmd_t  sdram_cmd;
	logic        sdram_req;
	logic        sdram_ack;
	logic [15:0] sdram_dout;

	// SDRAM model state
	logic [15:0] mem_words [logic [22:0]];
	sdram_cmd_t  last_cmd;
	int          req_count;
	integer      seed;

	zx_mem_top #(
		.ROM_BASE (ROM_BASE),
		.RAM_BASE (RAM_BASE)
	) dut_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.machine    (machine),
		.cpu_bus    (cpu_bus),
		.cpu_din    (cpu_din),
		.ram_ready  (ram_ready),
		.sdram_cmd  (sdram_cmd),
		.sdram_req  (sdram_req),
		.sdram_ack  (sdram_ack),
		.sdram_dout (sdram_dout)
	);

	initial begin
		clk_sys = 1'b0;
		forever #CLK_HALF clk_sys = ~clk_sys;
	end

	`include "tb_zx_mem_tasks.svh"

	// ==================================================
	// SDRAM model
	// ==================================================
	initial begin
		int          delay;
		logic [15:0] word;
		sdram_ack  = 1'b0;
		sdram_dout = 16'h0000;
		forever begin
			@(posedge clk_sys);
			#STIM_DLY;
			if (reset) begin
				sdram_ack = 1'b0; // Follows the port's reset value
			end else if (sdram_req != sdram_ack) begin
				last_cmd  = sdram_cmd;
				req_count = req_count + 1;
				delay = 1 + int'($unsigned($random(seed)) % 4);
				repeat (delay) @(posedge clk_sys);
				#STIM_DLY;
				word = fill_word(last_cmd.a);
				if (mem_words.exists(last_cmd.a))
					word = mem_words[last_cmd.a];
				if (last_cmd.we) begin
					if (last_cmd.ds[1])
						word[15:8] = last_cmd.d[15:8];
					if (last_cmd.ds[0])
						word[7:0] = last_cmd.d[7:0];
					mem_words[last_cmd.a] = word;
				end else begin
					sdram_dout = word;
				end
				sdram_ack = sdram_req;
			end
		end
	end

	// ==================================================
	// Test sequence
	// ==================================================
	initial begin
		seed      = 32'h87e1e119;
		req_count = 0;
		last_cmd  = '0;
		reset     = 1'b1;
		machine   = MACH_128;
		cpu_bus   = '0;

		test_ram_banking();
		test_rom_select();
		test_lock();
		test_plus3_special();
		test_byte_lanes();

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+dv
hdl/zx_mem_pkg.sv
hdl/cpu_bus_sync.sv
hdl/zx_paging.sv
hdl/sdram_port.sv
hdl/zx_mem_top.sv
dv/tb_zx_mem.sv

/* Makefile */
# Verilator build and run of the Spectrum memory path testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f files.f --top-module tb_zx_mem -o sim_tb
	./obj_dir/sim_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
